//--- project.f
src/uopPkg.sv
src/execPkg.sv
src/dispatchIntake.sv
src/reservationStation.sv
src/intAlu.sv
src/mulUnit.sv
src/port0Writeback.sv
src/issueCore.sv
tests/issueCoreTb.sv

//--- tests/issueCoreTb.sv
module issueCoreTb import uopPkg::*; ();

    localparam int CLK_PERIOD = 40;
    localparam int RESET_CYCLES = 10;
    localparam int RS_DEPTH = 8;
    localparam int RANDOM_OPS = 24;
    localparam int TOTAL_OPS = RANDOM_OPS + 3 + 5 + RS_DEPTH + 1;
    localparam int NUM_TAGS = 32;

    logic clk;
    logic rst;
    logic inReq;
    logic inAck;
    fuT   inFu;
    tagT  inTagA;
    logic inAvailA;
    tagT  inTagB;
    logic inAvailB;
    tagT  inTagDst;
    dataT inDataA;
    dataT inDataB;
    logic invalidate;
    sqNT  invalidateSqN;
    freeT free;
    logic resValid0;
    tagT  resTag0;
    sqNT  resSqN0;
    dataT resData0;
    logic resValid1;
    tagT  resTag1;
    sqNT  resSqN1;
    dataT resData1;

    // Reference model, one slot per destination tag
    dataT expVal [NUM_TAGS];
    sqNT  expSqN [NUM_TAGS];
    logic live [NUM_TAGS];
    int   seen [NUM_TAGS];
    int   arrival [NUM_TAGS];
    logic depA [NUM_TAGS];
    logic depB [NUM_TAGS];
    tagT  prodA [NUM_TAGS];
    tagT  prodB [NUM_TAGS];
    logic hasFollow [NUM_TAGS];
    tagT  follow [NUM_TAGS];

    int   cycle;
    int   outstanding;
    sqNT  seqCounter;
    tagT  nextTag;
    logic expectFull;
    int   valueErrors;
    int   orderErrors;
    int   otherErrors;

    issueCore #(.RS_DEPTH(RS_DEPTH)) issueCore_inst (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic dataT expectedResult(input fuT fu, input dataT a, input dataT b);
        logic [31:0] product;
        product = a * b;
        case (fu)
            FU_ADD: return a + b;
            FU_SUB: return a - b;
            FU_XOR: return a ^ b;
            default: return product[15:0];
        endcase
    endfunction

    // Wrapped age compare over the 6-bit number space
    function automatic logic younger(input sqNT a, input sqNT b);
        logic [5:0] gap;
        gap = a - b;
        return gap != 6'd0 && gap < 6'd32;
    endfunction

    function automatic logic orderOk(input tagT t);
        logic okA;
        logic okB;
        okA = !depA[t] || (seen[prodA[t]] > 0 && arrival[prodA[t]] < arrival[t]);
        okB = !depB[t] || (seen[prodB[t]] > 0 && arrival[prodB[t]] < arrival[t]);
        return okA && okB;
    endfunction

    function automatic logic followOk(input tagT t);
        return !hasFollow[t] || (seen[follow[t]] > 0 && arrival[t] == arrival[follow[t]] + 1);
    endfunction

    function automatic logic resultOk(input tagT t, input dataT d, input sqNT s);
        return d == expVal[t] && s == expSqN[t] && live[t] && seen[t] == 1
            && orderOk(t) && followOk(t);
    endfunction

    function automatic tagT newTag();
        tagT t;
        t = nextTag;
        nextTag = nextTag + 1'b1;
        hasFollow[t] = 1'b0;
        return t;
    endfunction

    task automatic reportResult(input int bus, input tagT t, input dataT d, input sqNT s);
        if (d != expVal[t] || s != expSqN[t]) begin
            valueErrors++;
            $display("Error at %0t: bus %0d tag %0d gave %h seq %0d, expected %h seq %0d",
                     $time, bus, t, d, s, expVal[t], expSqN[t]);
        end
        if (!live[t] || seen[t] != 1) begin
            otherErrors++;
            $display("Result for tag %0d on bus %0d was not expected or came twice", t, bus);
        end
        if (!orderOk(t)) begin
            orderErrors++;
            $display("Result for tag %0d came before a result it depends on", t);
        end
        if (!followOk(t)) begin
            otherErrors++;
            $display("Result for tag %0d missed the cycle right after its producer", t);
        end
    endtask

    // Mid-cycle bookkeeping so the checks at the next edge see settled state
    always @(negedge clk) begin
        cycle = cycle + 1;
        if (!rst && resValid0) begin
            seen[resTag0]++;
            arrival[resTag0] = cycle;
            if (live[resTag0] && seen[resTag0] == 1) outstanding--;
        end
        if (!rst && resValid1) begin
            seen[resTag1]++;
            arrival[resTag1] = cycle;
            if (live[resTag1] && seen[resTag1] == 1) outstanding--;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        resValid0 |-> resultOk(resTag0, resData0, resSqN0))
        else reportResult(0, $sampled(resTag0), $sampled(resData0), $sampled(resSqN0));

    assert property (@(posedge clk) disable iff (rst)
        resValid1 |-> resultOk(resTag1, resData1, resSqN1))
        else reportResult(1, $sampled(resTag1), $sampled(resData1), $sampled(resSqN1));

    assert property (@(posedge clk)
        $fell(rst) |-> !inAck && !resValid0 && !resValid1 && free == freeT'(RS_DEPTH))
        else begin
            otherErrors++;
            $display("Outputs were not in their reset state when reset was released");
        end

    assert property (@(posedge clk) disable iff (rst) expectFull |-> free == '0 && !inAck)
        else begin
            otherErrors++;
            $display("The full station accepted a request or did not report zero free entries");
        end

    // Four-phase handshake, entered and left on a rising edge
    task automatic sendOp(input fuT fu, input logic dependA, input tagT srcA,
                          input logic dependB, input tagT srcB, input tagT dst);
        dataT a;
        dataT b;
        a = dataT'($urandom);
        b = dataT'($urandom);
        expVal[dst] = expectedResult(fu, a, b);
        expSqN[dst] = seqCounter;
        live[dst] = 1'b1;
        seen[dst] = 0;
        depA[dst] = dependA;
        prodA[dst] = srcA;
        depB[dst] = dependB;
        prodB[dst] = srcB;
        seqCounter = seqCounter + 1'b1;
        outstanding++;
        inReq <= 1'b1;
        inFu <= fu;
        inTagA <= srcA;
        inAvailA <= !dependA;
        inTagB <= srcB;
        inAvailB <= !dependB;
        inTagDst <= dst;
        inDataA <= a;
        inDataB <= b;
        do @(posedge clk); while (!inAck);
        inReq <= 1'b0;
        do @(posedge clk); while (inAck);
    endtask

    task automatic drain();
        while (outstanding != 0 || free != freeT'(RS_DEPTH)) begin
            @(posedge clk);
        end
        repeat (6) @(posedge clk);
    endtask

    task automatic markKilled(input sqNT cut);
        for (int t = 0; t < NUM_TAGS; t++) begin
            if (live[t] && seen[t] == 0 && younger(expSqN[t], cut)) begin
                live[t] = 1'b0;
                outstanding--;
            end
        end
    endtask

    task automatic runRandomChains();
        tagT  prevTag;
        logic prevMul;
        fuT   fu;
        logic useA;
        logic useB;
        tagT  dst;
        prevMul = 1'b0;
        prevTag = '0;
        for (int i = 0; i < RANDOM_OPS; i++) begin
            fu = $urandom_range(1, 0) ? FU_MUL : fuT'($urandom_range(2, 0));
            // Only a multiply sent just before is still in flight when this op lands
            useA = prevMul && $urandom_range(1, 0) == 1;
            useB = prevMul && $urandom_range(1, 0) == 1;
            dst = newTag();
            sendOp(fu, useA, prevTag, useB, prevTag, dst);
            prevMul = fu == FU_MUL;
            prevTag = dst;
        end
    endtask

    // Two ALU ops wait on a producer sent after them, then issue on consecutive cycles
    task automatic runBackToBack();
        tagT late;
        tagT mid;
        tagT last;
        late = newTag();
        mid = newTag();
        last = newTag();
        hasFollow[mid] = 1'b1;
        follow[mid] = late;
        hasFollow[last] = 1'b1;
        follow[last] = mid;
        sendOp(FU_ADD, 1'b1, late, 1'b0, '0, mid);
        sendOp(FU_XOR, 1'b1, mid, 1'b0, '0, last);
        sendOp(FU_SUB, 1'b0, '0, 1'b0, '0, late);
    endtask

    // The last ALU op of the chain becomes ready two cycles after the multiply issues
    // and has to leave port 0 free for the multiply result
    task automatic blockAluBehindMul();
        tagT head;
        tagT mul;
        tagT side;
        tagT mid;
        tagT tail;
        head = newTag();
        mul = newTag();
        side = newTag();
        mid = newTag();
        tail = newTag();
        hasFollow[mid] = 1'b1;
        follow[mid] = side;
        hasFollow[tail] = 1'b1;
        follow[tail] = mid;
        sendOp(FU_MUL, 1'b1, head, 1'b0, '0, mul);
        sendOp(FU_ADD, 1'b1, head, 1'b0, '0, side);
        sendOp(FU_XOR, 1'b1, side, 1'b0, '0, mid);
        sendOp(FU_SUB, 1'b1, mid, 1'b0, '0, tail);
        sendOp(FU_ADD, 1'b0, '0, 1'b0, '0, head);
    endtask

    task automatic runBackPressure();
        tagT wakeTag;
        tagT blocked [RS_DEPTH];
        sqNT cutSqN;
        wakeTag = newTag();
        for (int i = 0; i < RS_DEPTH; i++) begin
            blocked[i] = newTag();
            sendOp(FU_ADD, 1'b1, wakeTag, 1'b0, '0, blocked[i]);
        end
        cutSqN = expSqN[blocked[1]];
        markKilled(cutSqN);
        fork
            sendOp(FU_ADD, 1'b0, '0, 1'b0, '0, wakeTag);
            begin
                expectFull <= 1'b1;
                repeat (12) @(posedge clk);
                expectFull <= 1'b0;
                invalidate <= 1'b1;
                invalidateSqN <= cutSqN;
                @(posedge clk);
                invalidate <= 1'b0;
            end
        join
    endtask

    initial begin
        void'($urandom(32'h6c53_a21d));
        rst = 1'b1;
        inReq = 1'b0;
        inFu = FU_ADD;
        inTagA = '0;
        inAvailA = 1'b0;
        inTagB = '0;
        inAvailB = 1'b0;
        inTagDst = '0;
        inDataA = '0;
        inDataB = '0;
        invalidate = 1'b0;
        invalidateSqN = '0;
        expectFull = 1'b0;
        cycle = 0;
        outstanding = 0;
        seqCounter = '0;
        nextTag = '0;
        valueErrors = 0;
        orderErrors = 0;
        otherErrors = 0;
        for (int t = 0; t < NUM_TAGS; t++) begin
            live[t] = 1'b0;
            seen[t] = 0;
            arrival[t] = 0;
            depA[t] = 1'b0;
            depB[t] = 1'b0;
            hasFollow[t] = 1'b0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        runRandomChains();
        drain();
        runBackToBack();
        drain();
        blockAluBehindMul();
        drain();
        runBackPressure();
        drain();
        $display("Errors: %0d value, %0d order, %0d other",
                 valueErrors, orderErrors, otherErrors);
        if (valueErrors + orderErrors + otherErrors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    initial begin
        repeat (RESET_CYCLES + 200 * TOTAL_OPS) @(posedge clk);
        $display("Watchdog expired with %0d results still outstanding", outstanding);
        $display("TB FAILED");
        $finish;
    end

endmodule

//--- src/issueCore.sv
module issueCore import uopPkg::*; #(
    parameter int RS_DEPTH = 8
) (
    input  logic clk,
    input  logic rst,
    input  logic inReq,
    output logic inAck,
    input  fuT   inFu,
    input  tagT  inTagA,
    input  logic inAvailA,
    input  tagT  inTagB,
    input  logic inAvailB,
    input  tagT  inTagDst,
    input  dataT inDataA,
    input  dataT inDataB,
    input  logic invalidate,
    input  sqNT  invalidateSqN,
    output freeT free,
    output logic resValid0,
    output tagT  resTag0,
    output sqNT  resSqN0,
    output dataT resData0,
    output logic resValid1,
    output tagT  resTag1,
    output sqNT  resSqN1,
    output dataT resData1
);

    logic enqValid;
    sqNT  enqSqN;
    fuT   enqFu;
    tagT  enqTagA;
    logic enqAvailA;
    tagT  enqTagB;
    logic enqAvailB;
    tagT  enqTagDst;
    dataT enqDataA;
    dataT enqDataB;

    logic issueValid0;
    fuT   issueFu0;
    sqNT  issueSqN0;
    tagT  issueTag0;
    dataT issueDataA0;
    dataT issueDataB0;
    logic issueValid1;
    fuT   issueFu1;
    sqNT  issueSqN1;
    tagT  issueTag1;
    dataT issueDataA1;
    dataT issueDataB1;

    dispatchIntake #(.RS_DEPTH(RS_DEPTH)) intake (
        .clk(clk), .rst(rst), .inReq(inReq), .inAck(inAck), .inFu(inFu),
        .inTagA(inTagA), .inAvailA(inAvailA), .inTagB(inTagB), .inAvailB(inAvailB),
        .inTagDst(inTagDst), .inDataA(inDataA), .inDataB(inDataB), .free(free),
        .enqValid(enqValid), .enqSqN(enqSqN), .enqFu(enqFu),
        .enqTagA(enqTagA), .enqAvailA(enqAvailA), .enqTagB(enqTagB), .enqAvailB(enqAvailB),
        .enqTagDst(enqTagDst), .enqDataA(enqDataA), .enqDataB(enqDataB)
    );

    reservationStation #(.RS_DEPTH(RS_DEPTH)) station (
        .clk(clk), .rst(rst), .enqValid(enqValid), .enqSqN(enqSqN), .enqFu(enqFu),
        .enqTagA(enqTagA), .enqAvailA(enqAvailA), .enqTagB(enqTagB), .enqAvailB(enqAvailB),
        .enqTagDst(enqTagDst), .enqDataA(enqDataA), .enqDataB(enqDataB), .free(free),
        .resValid0(resValid0), .resTag0(resTag0), .resSqN0(resSqN0),
        .resValid1(resValid1), .resTag1(resTag1), .resSqN1(resSqN1),
        .invalidate(invalidate), .invalidateSqN(invalidateSqN),
        .issueValid0(issueValid0), .issueFu0(issueFu0), .issueSqN0(issueSqN0),
        .issueTag0(issueTag0), .issueDataA0(issueDataA0), .issueDataB0(issueDataB0),
        .issueValid1(issueValid1), .issueFu1(issueFu1), .issueSqN1(issueSqN1),
        .issueTag1(issueTag1), .issueDataA1(issueDataA1), .issueDataB1(issueDataB1)
    );

    port0Writeback port0 (
        .clk(clk), .rst(rst), .issueValid(issueValid0), .issueFu(issueFu0),
        .issueSqN(issueSqN0), .issueTag(issueTag0),
        .issueDataA(issueDataA0), .issueDataB(issueDataB0),
        .invalidate(invalidate), .invalidateSqN(invalidateSqN),
        .resValid(resValid0), .resTag(resTag0), .resSqN(resSqN0), .resData(resData0)
    );

    // Port 1 only ever carries ALU ops
    intAlu port1 (
        .clk(clk), .rst(rst), .issueValid(issueValid1), .issueFu(issueFu1),
        .issueSqN(issueSqN1), .issueTag(issueTag1),
        .issueDataA(issueDataA1), .issueDataB(issueDataB1),
        .invalidate(invalidate), .invalidateSqN(invalidateSqN),
        .resValid(resValid1), .resTag(resTag1), .resSqN(resSqN1), .resData(resData1)
    );

endmodule

//--- src/port0Writeback.sv
module port0Writeback import uopPkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic issueValid,
    input  fuT   issueFu,
    input  sqNT  issueSqN,
    input  tagT  issueTag,
    input  dataT issueDataA,
    input  dataT issueDataB,
    input  logic invalidate,
    input  sqNT  invalidateSqN,
    output logic resValid,
    output tagT  resTag,
    output sqNT  resSqN,
    output dataT resData
);

    logic aluIssue;
    logic mulIssue;
    logic aluValid;
    logic mulValid;
    tagT  aluTag;
    tagT  mulTag;
    sqNT  aluSqN;
    sqNT  mulSqN;
    dataT aluData;
    dataT mulData;

    assign aluIssue = issueValid && issueFu != FU_MUL;
    assign mulIssue = issueValid && issueFu == FU_MUL;

    intAlu alu0 (
        .clk(clk), .rst(rst), .issueValid(aluIssue), .issueFu(issueFu),
        .issueSqN(issueSqN), .issueTag(issueTag),
        .issueDataA(issueDataA), .issueDataB(issueDataB),
        .invalidate(invalidate), .invalidateSqN(invalidateSqN),
        .resValid(aluValid), .resTag(aluTag), .resSqN(aluSqN), .resData(aluData)
    );

    mulUnit mul0 (
        .clk(clk), .rst(rst), .issueValid(mulIssue), .issueFu(issueFu),
        .issueSqN(issueSqN), .issueTag(issueTag),
        .issueDataA(issueDataA), .issueDataB(issueDataB),
        .invalidate(invalidate), .invalidateSqN(invalidateSqN),
        .mulValid(mulValid), .mulTag(mulTag), .mulSqN(mulSqN), .mulData(mulData)
    );

    assign resValid = mulValid || aluValid;
    assign resTag = mulValid ? mulTag : aluTag;
    assign resSqN = mulValid ? mulSqN : aluSqN;
    assign resData = mulValid ? mulData : aluData;

    // The station's write-back reservation keeps these apart
    assert property (@(posedge clk) disable iff (rst) !(mulValid && aluValid))
        else $error("ALU and multiplier collided on result bus 0");

endmodule

//--- src/mulUnit.sv
module mulUnit import uopPkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic issueValid,
    input  fuT   issueFu,
    input  sqNT  issueSqN,
    input  tagT  issueTag,
    input  dataT issueDataA,
    input  dataT issueDataB,
    input  logic invalidate,
    input  sqNT  invalidateSqN,
    output logic mulValid,
    output tagT  mulTag,
    output sqNT  mulSqN,
    output dataT mulData
);

    logic       s1Valid;
    logic       s2Valid;
    tagT        s1Tag;
    tagT        s2Tag;
    sqNT        s1SqN;
    sqNT        s2SqN;
    dataT       s1A;
    dataT       s1B;
    dataT       s2A;
    logic [7:0] s2BHigh;
    dataT       s2Part;

    function automatic logic killed(input sqNT s);
        return invalidate && isYounger(s, invalidateSqN);
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            s1Valid <= 1'b0;
            s2Valid <= 1'b0;
            mulValid <= 1'b0;
        end else begin
            s1Valid <= issueValid && issueFu == FU_MUL && !killed(issueSqN);
            s2Valid <= s1Valid && !killed(s1SqN);
            mulValid <= s2Valid && !killed(s2SqN);
        end
    end

    always_ff @(posedge clk) begin
        s1Tag <= issueTag;
        s1SqN <= issueSqN;
        s1A <= issueDataA;
        s1B <= issueDataB;

        // Low multiplier byte here, high byte shifted in on the last stage
        s2Tag <= s1Tag;
        s2SqN <= s1SqN;
        s2A <= s1A;
        s2BHigh <= s1B[15:8];
        s2Part <= s1A * s1B[7:0];

        mulTag <= s2Tag;
        mulSqN <= s2SqN;
        mulData <= s2Part + ((s2A * s2BHigh) << 8);
    end

endmodule

//--- src/intAlu.sv
module intAlu import uopPkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic issueValid,
    input  fuT   issueFu,
    input  sqNT  issueSqN,
    input  tagT  issueTag,
    input  dataT issueDataA,
    input  dataT issueDataB,
    input  logic invalidate,
    input  sqNT  invalidateSqN,
    output logic resValid,
    output tagT  resTag,
    output sqNT  resSqN,
    output dataT resData
);

    dataT aluOut;

    always_comb begin
        case (issueFu)
            FU_SUB: aluOut = issueDataA - issueDataB;
            FU_XOR: aluOut = issueDataA ^ issueDataB;
            // Multiplies are never steered here
            default: aluOut = issueDataA + issueDataB;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            resValid <= 1'b0;
        end else begin
            resValid <= issueValid && !(invalidate && isYounger(issueSqN, invalidateSqN));
        end
    end

    always_ff @(posedge clk) begin
        resTag <= issueTag;
        resSqN <= issueSqN;
        resData <= aluOut;
    end

endmodule

//--- src/reservationStation.sv
module reservationStation import uopPkg::*, execPkg::*; #(
    parameter int RS_DEPTH = 8
) (
    input  logic clk,
    input  logic rst,
    input  logic enqValid,
    input  sqNT  enqSqN,
    input  fuT   enqFu,
    input  tagT  enqTagA,
    input  logic enqAvailA,
    input  tagT  enqTagB,
    input  logic enqAvailB,
    input  tagT  enqTagDst,
    input  dataT enqDataA,
    input  dataT enqDataB,
    output freeT free,
    input  logic resValid0,
    input  tagT  resTag0,
    input  sqNT  resSqN0,
    input  logic resValid1,
    input  tagT  resTag1,
    input  sqNT  resSqN1,
    input  logic invalidate,
    input  sqNT  invalidateSqN,
    output logic issueValid0,
    output fuT   issueFu0,
    output sqNT  issueSqN0,
    output tagT  issueTag0,
    output dataT issueDataA0,
    output dataT issueDataB0,
    output logic issueValid1,
    output fuT   issueFu1,
    output sqNT  issueSqN1,
    output tagT  issueTag1,
    output dataT issueDataA1,
    output dataT issueDataB1
);

    localparam int IDX_W = $clog2(RS_DEPTH);

    logic [RS_DEPTH-1:0] entValid;
    logic [RS_DEPTH-1:0] entAvailA;
    logic [RS_DEPTH-1:0] entAvailB;
    sqNT  entSqN [RS_DEPTH];
    fuT   entFu [RS_DEPTH];
    tagT  entTagA [RS_DEPTH];
    tagT  entTagB [RS_DEPTH];
    tagT  entTagDst [RS_DEPTH];
    dataT entDataA [RS_DEPTH];
    dataT entDataB [RS_DEPTH];

    wbSlotsT wbSlots;

    logic [RS_DEPTH-1:0] live;
    logic [RS_DEPTH-1:0] ready;
    logic [RS_DEPTH-1:0] cand0;
    logic [RS_DEPTH-1:0] cand1;
    logic [RS_DEPTH-1:0] nextValid;
    logic                selValid [NUM_PORTS];
    logic [IDX_W-1:0]    selIdx [NUM_PORTS];
    logic [IDX_W-1:0]    enqIdx;
    logic                enqKeep;
    logic                mulIssue;
    freeT                nextFree;

    function automatic logic dying(input sqNT s);
        return invalidate && isYounger(s, invalidateSqN);
    endfunction

    // Result buses and ALU ops sitting in the issue registers
    function automatic logic wakes(input tagT t);
        return (resValid0 && resTag0 == t && !dying(resSqN0))
            || (resValid1 && resTag1 == t && !dying(resSqN1))
            || (issueValid0 && issueFu0 != FU_MUL && issueTag0 == t && !dying(issueSqN0))
            || (issueValid1 && issueTag1 == t && !dying(issueSqN1));
    endfunction

    // Tournament over a heap of 2*RS_DEPTH nodes, leaves at RS_DEPTH and up
    function automatic logic [IDX_W:0] pickOldest(input logic [RS_DEPTH-1:0] cand,
                                                  input sqNT sqns [RS_DEPTH]);
        logic             nodeValid [2*RS_DEPTH];
        logic [IDX_W-1:0] nodeIdx [2*RS_DEPTH];
        sqNT              nodeSqN [2*RS_DEPTH];
        for (int i = 0; i < RS_DEPTH; i++) begin
            nodeValid[RS_DEPTH+i] = cand[i];
            nodeIdx[RS_DEPTH+i] = IDX_W'(i);
            nodeSqN[RS_DEPTH+i] = sqns[i];
        end
        for (int k = RS_DEPTH - 1; k >= 1; k--) begin
            if (nodeValid[2*k] &&
                (!nodeValid[2*k+1] || isYounger(nodeSqN[2*k+1], nodeSqN[2*k]))) begin
                nodeValid[k] = 1'b1;
                nodeIdx[k] = nodeIdx[2*k];
                nodeSqN[k] = nodeSqN[2*k];
            end else begin
                nodeValid[k] = nodeValid[2*k+1];
                nodeIdx[k] = nodeIdx[2*k+1];
                nodeSqN[k] = nodeSqN[2*k+1];
            end
        end
        return {nodeValid[1], nodeIdx[1]};
    endfunction

    always_comb begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            live[i] = entValid[i] && !dying(entSqN[i]);
            ready[i] = (entAvailA[i] || wakes(entTagA[i])) && (entAvailB[i] || wakes(entTagB[i]));
            // wbSlots[0] means a multiply lands on bus 0 where this ALU result would
            cand0[i] = live[i] && ready[i] && !(entFu[i] != FU_MUL && wbSlots[0]);
        end
        {selValid[0], selIdx[0]} = pickOldest(cand0, entSqN);

        for (int i = 0; i < RS_DEPTH; i++) begin
            cand1[i] = live[i] && ready[i] && entFu[i] != FU_MUL
                && !(selValid[0] && selIdx[0] == IDX_W'(i));
        end
        {selValid[1], selIdx[1]} = pickOldest(cand1, entSqN);

        mulIssue = selValid[0] && entFu[selIdx[0]] == FU_MUL;

        enqIdx = '0;
        for (int i = RS_DEPTH - 1; i >= 0; i--) begin
            if (!entValid[i]) begin
                enqIdx = IDX_W'(i);
            end
        end
        enqKeep = enqValid && !dying(enqSqN);

        nextValid = live;
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (selValid[p]) begin
                nextValid[selIdx[p]] = 1'b0;
            end
        end
        if (enqKeep) begin
            nextValid[enqIdx] = 1'b1;
        end

        nextFree = '0;
        for (int i = 0; i < RS_DEPTH; i++) begin
            nextFree = nextFree + freeT'(!nextValid[i]);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            entValid <= '0;
            free <= freeT'(RS_DEPTH);
            wbSlots <= '0;
            issueValid0 <= 1'b0;
            issueValid1 <= 1'b0;
        end else begin
            entValid <= nextValid;
            free <= nextFree;
            wbSlots <= (wbSlots >> 1) | (wbSlotsT'(mulIssue) << ($bits(wbSlotsT) - 1));
            issueValid0 <= selValid[0];
            issueValid1 <= selValid[1];
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            entAvailA[i] <= entAvailA[i] || wakes(entTagA[i]);
            entAvailB[i] <= entAvailB[i] || wakes(entTagB[i]);
        end
        if (enqKeep) begin
            entSqN[enqIdx] <= enqSqN;
            entFu[enqIdx] <= enqFu;
            entTagA[enqIdx] <= enqTagA;
            entTagB[enqIdx] <= enqTagB;
            entTagDst[enqIdx] <= enqTagDst;
            entAvailA[enqIdx] <= enqAvailA || wakes(enqTagA);
            entAvailB[enqIdx] <= enqAvailB || wakes(enqTagB);
            entDataA[enqIdx] <= enqDataA;
            entDataB[enqIdx] <= enqDataB;
        end

        issueFu0 <= entFu[selIdx[0]];
        issueSqN0 <= entSqN[selIdx[0]];
        issueTag0 <= entTagDst[selIdx[0]];
        issueDataA0 <= entDataA[selIdx[0]];
        issueDataB0 <= entDataB[selIdx[0]];

        issueFu1 <= entFu[selIdx[1]];
        issueSqN1 <= entSqN[selIdx[1]];
        issueTag1 <= entTagDst[selIdx[1]];
        issueDataA1 <= entDataA[selIdx[1]];
        issueDataB1 <= entDataB[selIdx[1]];
    end

    assert property (@(posedge clk) disable iff (rst) free <= RS_DEPTH)
        else $error("free count above station depth");

    assert property (@(posedge clk) disable iff (rst)
        issueValid0 && issueValid1 |-> issueSqN0 != issueSqN1)
        else $error("same micro-op issued on both ports");

endmodule

//--- src/dispatchIntake.sv
module dispatchIntake import uopPkg::*; #(
    parameter int RS_DEPTH = 8
) (
    input  logic clk,
    input  logic rst,
    input  logic inReq,
    output logic inAck,
    input  fuT   inFu,
    input  tagT  inTagA,
    input  logic inAvailA,
    input  tagT  inTagB,
    input  logic inAvailB,
    input  tagT  inTagDst,
    input  dataT inDataA,
    input  dataT inDataB,
    input  freeT free,
    output logic enqValid,
    output sqNT  enqSqN,
    output fuT   enqFu,
    output tagT  enqTagA,
    output logic enqAvailA,
    output tagT  enqTagB,
    output logic enqAvailB,
    output tagT  enqTagDst,
    output dataT enqDataA,
    output dataT enqDataB
);

    typedef enum logic [1:0] {
        IDLE,
        ACK_HIGH,
        REQ_LOW
    } stateT;

    stateT state;
    sqNT   nextSqN;
    logic  accept;

    // Wrapped age compare holds only while live ops span under half the number space
    if (2 * RS_DEPTH > (1 << $bits(sqNT))) begin : gDepthCheck
        $error("RS_DEPTH too large for the sequence number width");
    end

    assign accept = (state == IDLE) && inReq && (free != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            inAck <= 1'b0;
            enqValid <= 1'b0;
            nextSqN <= '0;
        end else begin
            enqValid <= accept;
            case (state)
                IDLE: begin
                    if (accept) begin
                        inAck <= 1'b1;
                        nextSqN <= nextSqN + 1'b1;
                        state <= ACK_HIGH;
                    end
                end
                ACK_HIGH: begin
                    if (!inReq) begin
                        inAck <= 1'b0;
                        state <= REQ_LOW;
                    end
                end
                // One quiet cycle with both lines low before the next request
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            enqSqN <= nextSqN;
            enqFu <= inFu;
            enqTagA <= inTagA;
            enqAvailA <= inAvailA;
            enqTagB <= inTagB;
            enqAvailB <= inAvailB;
            enqTagDst <= inTagDst;
            enqDataA <= inDataA;
            enqDataB <= inDataB;
        end
    end

    assert property (@(posedge clk) disable iff (rst) enqValid |-> free != '0)
        else $error("micro-op written into a full station");

endmodule

//--- src/execPkg.sv
package execPkg;

    // Cycles from issue to the result on the bus
    localparam int ALU_LATENCY = 1;
    localparam int MUL_LATENCY = 3;

    // One result bus per issue port
    localparam int NUM_PORTS = 2;

    // Bus 0 slots a multiply holds ahead of a later ALU result
    typedef logic [MUL_LATENCY-ALU_LATENCY-1:0] wbSlotsT;

endpackage

//--- src/uopPkg.sv
package uopPkg;

    typedef logic [5:0] sqNT;
    typedef logic [4:0] tagT;
    typedef logic [15:0] dataT;

    // Entry count of the station, 0 up to its depth
    typedef logic [3:0] freeT;

    typedef enum logic [1:0] {
        FU_ADD,
        FU_SUB,
        FU_XOR,
        FU_MUL
    } fuT;

    // True when a is younger than b, by the sign of the wrapped difference
    function automatic logic isYounger(input sqNT a, input sqNT b);
        sqNT diff;
        diff = a - b;
        return !diff[$bits(sqNT)-1] && (diff != '0);
    endfunction

endpackage
